// ==== source/cpuIsa.sv ====
// instruction set package: word and field widths, opcodes and instruction layout
`default_nettype none

package cpuIsa;

    localparam int numRegs  = 8;                  // general purpose registers
    localparam int wordBits = 16;                 // data, address and instruction width
    localparam int regBits  = $clog2(numRegs);    // register index width
    localparam int opBits   = 3;                  // opcode width
    localparam int immBits  = wordBits - opBits - 1 - regBits; // 9-bit immediate / offset

    typedef logic [wordBits-1:0] wordT;           // data word or address
    typedef logic [regBits-1:0]  regIdT;          // register index
    typedef logic [immBits-1:0]  immT;            // immediate or branch offset

    // opcode 1 is mvt with M set, branch with M clear
    typedef enum logic [opBits-1:0] {
        opMv    = 3'd0,                           // X <- Y or #imm
        opMvtB  = 3'd1,                           // mvt or always-taken branch
        opAdd   = 3'd2,                           // X <- X + op2
        opSub   = 3'd3,                           // X <- X - op2
        opLd    = 3'd4,                           // X <- mem[Y]
        opSt    = 3'd5,                           // mem[Y] <- X
        opAnd   = 3'd6,                           // X <- X & op2
        opOther = 3'd7                            // executes as a nop
    } opcodeT;

    // III M XXX DDDDDDDDD, Y sits in the low three bits of field
    typedef struct packed {
        opcodeT op;                               // operation
        logic   imm;                              // M flag, immediate operand
        regIdT  x;                                // destination / first source
        immT    field;                            // immediate or Y in [2:0]
    } instrT;

endpackage

`default_nettype wire

// ==== source/pipeLatch.sv ====
// pipeline package: ALU operations and the latches passed between the five stages
`default_nettype none

package pipeLatch;

    typedef enum logic [2:0] {
        aluPass,                                  // result = op2
        aluAdd,                                   // op1 + op2
        aluSub,                                   // op1 - op2
        aluAnd,                                   // op1 & op2
        aluHigh                                   // low immediate byte moved to upper byte
    } aluOpT;

    typedef struct packed {
        logic        valid;                       // slot holds a real instruction
        cpuIsa::wordT instr;                      // raw instruction word
        cpuIsa::wordT pc;                         // address it was fetched from
    } fetchLatchT;

    typedef struct packed {
        logic          valid;
        cpuIsa::regIdT dest;                      // X field
        cpuIsa::wordT  op1;                       // value of X, store data
        cpuIsa::wordT  op2;                       // Y, immediate or branch offset
        aluOpT         aluOp;
        logic          read;                      // load
        logic          write;                     // store
        logic          branch;                    // redirect in execute
        logic          writeback;                 // result goes to X
        cpuIsa::wordT  pc;
    } decodeLatchT;

    typedef struct packed {
        logic          valid;
        cpuIsa::regIdT dest;
        cpuIsa::wordT  result;                    // ALU output
        cpuIsa::wordT  storeData;
        cpuIsa::wordT  addr;                      // data port address
        logic          read;
        logic          write;
        logic          writeback;
    } execLatchT;

    typedef struct packed {
        logic          valid;
        cpuIsa::regIdT dest;
        cpuIsa::wordT  result;                    // ALU result or loaded word
        logic          writeback;
    } memLatchT;

    typedef struct packed {
        logic         taken;                      // one-cycle redirect request
        cpuIsa::wordT target;                     // new program counter
    } redirectT;

endpackage

`default_nettype wire

// ==== source/fetchStage.sv ====
// fetch stage: program counter, instruction port and the fetch latch
`default_nettype none

module fetchStage #(
    parameter cpuIsa::wordT resetPc = '0          // first instruction address
) (
    input  logic                   Clock,
    input  logic                   reset,
    input  logic                   hold,          // global freeze
    input  logic                   stallFetch,    // hazard in decode
    input  pipeLatch::redirectT    redirect,      // taken branch from execute
    input  cpuIsa::wordT           InstrIn,
    output cpuIsa::wordT           InstrAddr,
    output pipeLatch::fetchLatchT  fetchLatch
);

    cpuIsa::wordT pc;                             // separate from register 7

    assign InstrAddr = pc;                        // instruction memory answers same cycle

    always_ff @(posedge Clock) begin
        if (reset) begin
            pc               <= resetPc;
            fetchLatch.valid <= 1'b0;
        end else if (!hold) begin
            if (redirect.taken) begin
                pc               <= redirect.target;  // jump, drop the younger fetch
                fetchLatch.valid <= 1'b0;
            end else if (!stallFetch) begin
                pc         <= pc + cpuIsa::wordT'(1);
                fetchLatch <= '{valid: 1'b1, instr: InstrIn, pc: pc};
            end
            // on a stall both pc and latch keep their value
        end
    end

endmodule

`default_nettype wire

// ==== source/registerFile.sv ====
// register file: eight words, two combinational read ports, one write-through port
`default_nettype none

module registerFile (
    input  logic                Clock,
    input  logic                reset,
    input  logic                hold,             // no write while frozen
    input  cpuIsa::regIdT       readA,
    input  cpuIsa::regIdT       readB,
    output cpuIsa::wordT        dataA,
    output cpuIsa::wordT        dataB,
    input  pipeLatch::memLatchT writeReq          // writeback request
);

    cpuIsa::wordT regs [cpuIsa::numRegs];
    logic         writeEn;

    assign writeEn = writeReq.valid && writeReq.writeback && !hold;

    // same-cycle write is visible to decode, so no hazard on the memory latch
    assign dataA = (writeEn && writeReq.dest == readA) ? writeReq.result : regs[readA];
    assign dataB = (writeEn && writeReq.dest == readB) ? writeReq.result : regs[readB];

    always_ff @(posedge Clock) begin
        if (reset) begin
            for (int i = 0; i < cpuIsa::numRegs; i++) begin
                regs[i] <= '0;                    // all registers start at zero
            end
        end else if (writeEn) begin
            regs[writeReq.dest] <= writeReq.result;
        end
    end

endmodule

`default_nettype wire

// ==== source/decodeStage.sv ====
// decode stage: field split, operand read, read-after-write stall and the decode latch
`default_nettype none

module decodeStage (
    input  logic                   Clock,
    input  logic                   reset,
    input  logic                   hold,
    input  logic                   flush,         // branch taken in execute
    input  pipeLatch::fetchLatchT  fetchLatch,
    input  pipeLatch::decodeLatchT execView,      // own latch, seen by execute
    input  pipeLatch::execLatchT   execLatch,
    output cpuIsa::regIdT          readA,
    output cpuIsa::regIdT          readB,
    input  cpuIsa::wordT           dataA,
    input  cpuIsa::wordT           dataB,
    output logic                   stallFetch,
    output pipeLatch::decodeLatchT decodeLatch
);

    cpuIsa::instrT         instr;
    cpuIsa::wordT          immZero;               // zero-extended field
    cpuIsa::wordT          immSign;               // sign-extended branch offset
    pipeLatch::decodeLatchT next;
    logic                  usesX;                 // X is a source
    logic                  usesY;                 // Y is a source

    // result for r still in flight ahead of us
    function automatic logic pending(input cpuIsa::regIdT r);
        return (execView.valid && execView.writeback && execView.dest == r) ||
               (execLatch.valid && execLatch.writeback && execLatch.dest == r);
    endfunction

    assign instr   = cpuIsa::instrT'(fetchLatch.instr);
    assign readA   = instr.x;
    assign readB   = instr.field[cpuIsa::regBits-1:0];
    assign immZero = cpuIsa::wordT'(instr.field);
    assign immSign = {{(cpuIsa::wordBits - cpuIsa::immBits){instr.field[cpuIsa::immBits-1]}},
                      instr.field};

    always_comb begin
        next           = '0;
        next.valid     = fetchLatch.valid;
        next.dest      = instr.x;
        next.op1       = dataA;
        next.op2       = instr.imm ? immZero : dataB;
        next.aluOp     = pipeLatch::aluPass;      // mv by default
        next.writeback = 1'b1;
        next.pc        = fetchLatch.pc;
        usesX          = 1'b0;
        usesY          = !instr.imm;
        unique case (instr.op)
            cpuIsa::opMv: ;                       // pass op2 through
            cpuIsa::opMvtB: begin
                usesY = 1'b0;
                if (instr.imm) begin
                    next.aluOp = pipeLatch::aluHigh;
                end else begin
                    next.branch    = 1'b1;        // always taken
                    next.writeback = 1'b0;
                    next.op2       = immSign;
                end
            end
            cpuIsa::opAdd: begin
                next.aluOp = pipeLatch::aluAdd;
                usesX      = 1'b1;
            end
            cpuIsa::opSub: begin
                next.aluOp = pipeLatch::aluSub;
                usesX      = 1'b1;
            end
            cpuIsa::opAnd: begin
                next.aluOp = pipeLatch::aluAnd;
                usesX      = 1'b1;
            end
            cpuIsa::opLd: begin
                next.read = 1'b1;
                next.op2  = dataB;                // address always from Y
                usesY     = 1'b1;
            end
            cpuIsa::opSt: begin
                next.write     = 1'b1;
                next.writeback = 1'b0;
                next.op2       = dataB;
                usesX          = 1'b1;            // store data
                usesY          = 1'b1;            // address
            end
            cpuIsa::opOther: begin
                next.valid = 1'b0;                // nop
                usesY      = 1'b0;
            end
        endcase
    end

    assign stallFetch = fetchLatch.valid &&
                        ((usesX && pending(readA)) || (usesY && pending(readB)));

    always_ff @(posedge Clock) begin
        if (reset) begin
            decodeLatch.valid <= 1'b0;
        end else if (!hold) begin
            if (flush || stallFetch) begin
                decodeLatch <= '0;                // bubble
            end else begin
                decodeLatch <= next;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/executeStage.sv ====
// execute stage: ALU, branch target and redirect, and the execute latch
`default_nettype none

module executeStage (
    input  logic                   Clock,
    input  logic                   reset,
    input  logic                   hold,
    input  pipeLatch::decodeLatchT decodeLatch,
    output pipeLatch::redirectT    redirect,
    output pipeLatch::execLatchT   execLatch
);

    cpuIsa::wordT aluOut;

    always_comb begin
        unique case (decodeLatch.aluOp)
            pipeLatch::aluAdd:  aluOut = decodeLatch.op1 + decodeLatch.op2;
            pipeLatch::aluSub:  aluOut = decodeLatch.op1 - decodeLatch.op2;
            pipeLatch::aluAnd:  aluOut = decodeLatch.op1 & decodeLatch.op2;
            pipeLatch::aluHigh: aluOut = decodeLatch.op2 << (cpuIsa::wordBits / 2); // byte up
            default:            aluOut = decodeLatch.op2;  // pass
        endcase
    end

    // offset is relative to the address after the branch
    assign redirect.taken  = decodeLatch.valid && decodeLatch.branch;
    assign redirect.target = decodeLatch.pc + cpuIsa::wordT'(1) + decodeLatch.op2;

    always_ff @(posedge Clock) begin
        if (reset) begin
            execLatch.valid <= 1'b0;
        end else if (!hold) begin
            execLatch.valid     <= decodeLatch.valid && !decodeLatch.branch; // branch done here
            execLatch.dest      <= decodeLatch.dest;
            execLatch.result    <= aluOut;
            execLatch.storeData <= decodeLatch.op1;   // X for st
            execLatch.addr      <= decodeLatch.op2;   // Y for ld / st
            execLatch.read      <= decodeLatch.read;
            execLatch.write     <= decodeLatch.write;
            execLatch.writeback <= decodeLatch.writeback;
        end
    end

endmodule

`default_nettype wire

// ==== source/memoryStage.sv ====
// memory stage: data port drive and the memory latch feeding writeback
`default_nettype none

module memoryStage (
    input  logic                 Clock,
    input  logic                 reset,
    input  logic                 hold,
    input  logic                 Enable,
    input  logic                 DataWaitreq,
    input  pipeLatch::execLatchT execLatch,
    input  cpuIsa::wordT         DataIn,
    output cpuIsa::wordT         DataAddr,
    output cpuIsa::wordT         DataOut,
    output logic                 ReadData,
    output logic                 WriteData,
    output logic                 accessActive,    // ld or st in this stage
    output pipeLatch::memLatchT  memLatch
);

    logic waiting;                                // memory not ready yet

    assign accessActive = execLatch.valid && (execLatch.read || execLatch.write);
    assign waiting      = accessActive && DataWaitreq;

    // address and data come straight from the latch, so they stay put during a wait
    assign DataAddr  = execLatch.addr;
    assign DataOut   = execLatch.storeData;
    assign ReadData  = Enable && execLatch.valid && execLatch.read;
    assign WriteData = Enable && execLatch.valid && execLatch.write;

    always_ff @(posedge Clock) begin
        if (reset) begin
            memLatch.valid <= 1'b0;
        end else if (!hold && !waiting) begin    // read data is only taken once ready
            memLatch.valid     <= execLatch.valid;
            memLatch.dest      <= execLatch.dest;
            memLatch.result    <= execLatch.read ? DataIn : execLatch.result;
            memLatch.writeback <= execLatch.writeback;
        end
    end

endmodule

`default_nettype wire

// ==== source/processor.sv ====
// processor top: five-stage pipeline with split instruction and data ports
`default_nettype none

module processor #(
    parameter cpuIsa::wordT resetPc = '0          // start address after reset
) (
    input  logic         Clock,
    input  logic         reset,
    input  logic         Enable,                  // low freezes everything
    input  cpuIsa::wordT InstrIn,
    input  cpuIsa::wordT DataIn,
    input  logic         DataWaitreq,
    output cpuIsa::wordT InstrAddr,
    output cpuIsa::wordT DataAddr,
    output cpuIsa::wordT DataOut,
    output logic         ReadData,
    output logic         WriteData
);

    pipeLatch::fetchLatchT  fetchLatch;
    pipeLatch::decodeLatchT decodeLatch;
    pipeLatch::execLatchT   execLatch;
    pipeLatch::memLatchT    memLatch;            // writeback request
    pipeLatch::redirectT    redirect;
    cpuIsa::regIdT          readA;
    cpuIsa::regIdT          readB;
    cpuIsa::wordT           dataA;
    cpuIsa::wordT           dataB;
    logic                   stallFetch;
    logic                   accessActive;
    logic                   hold;

    // one freeze for every latch and the register file
    assign hold = !Enable || (accessActive && DataWaitreq);

    fetchStage #(.resetPc(resetPc)) fetch_i (
        .Clock, .reset, .hold, .stallFetch, .redirect,
        .InstrIn, .InstrAddr, .fetchLatch
    );

    registerFile regFile_i (
        .Clock, .reset, .hold, .readA, .readB, .dataA, .dataB,
        .writeReq (memLatch)
    );

    decodeStage decode_i (
        .Clock, .reset, .hold,
        .flush    (redirect.taken),
        .fetchLatch,
        .execView (decodeLatch),                  // hazard check against own latch
        .execLatch, .readA, .readB, .dataA, .dataB, .stallFetch, .decodeLatch
    );

    executeStage execute_i (
        .Clock, .reset, .hold, .decodeLatch, .redirect, .execLatch
    );

    memoryStage memory_i (
        .Clock, .reset, .hold, .Enable, .DataWaitreq, .execLatch, .DataIn,
        .DataAddr, .DataOut, .ReadData, .WriteData, .accessActive, .memLatch
    );

endmodule

`default_nettype wire

// ==== tests/isaModel.svh ====
// ISA reference model: runs one program instruction by instruction and lists its stores
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

typedef struct packed {
    cpuIsa::wordT addr;                           // data port address
    cpuIsa::wordT data;                           // stored word
} storeT;

localparam int modelStepLimit = 1000;             // stops a program that never ends

function automatic void runModel(input cpuIsa::wordT prog [progWords],
                                 input cpuIsa::wordT initMem [256],
                                 output storeT stores [$]);
    cpuIsa::wordT regs [8];
    cpuIsa::wordT mem [256];
    cpuIsa::wordT pc;
    cpuIsa::wordT word;
    cpuIsa::wordT op2;
    logic [2:0]   x;
    logic [2:0]   y;
    logic [8:0]   field;
    stores = {};
    mem    = initMem;
    pc     = '0;
    for (int i = 0; i < 8; i++) begin
        regs[i] = '0;                             // registers start cleared
    end
    for (int step = 0; step < modelStepLimit; step++) begin
        word  = prog[pc[5:0]];
        x     = word[11:9];
        field = word[8:0];
        y     = field[2:0];
        op2   = word[12] ? {7'd0, field} : regs[y];   // M picks immediate or Y
        pc    = pc + 16'd1;                       // address after this instruction
        case (word[15:13])
            3'd0: regs[x] = op2;                  // mv
            3'd1: begin
                if (word[12]) begin
                    regs[x] = {field[7:0], 8'h00};    // mvt
                end else if (field == 9'h1FF) begin
                    break;                        // branch to itself ends the program
                end else begin
                    pc = pc + {{7{field[8]}}, field}; // always taken
                end
            end
            3'd2: regs[x] = regs[x] + op2;
            3'd3: regs[x] = regs[x] - op2;
            3'd4: regs[x] = mem[regs[y][7:0]];    // ld, 256-word data memory
            3'd5: begin
                mem[regs[y][7:0]] = regs[x];
                stores.push_back('{addr: regs[y], data: regs[x]});
            end
            3'd6: regs[x] = regs[x] & op2;
            default: ;                            // opcode 7 is a nop
        endcase
    end
endfunction

`endif

// ==== tests/processorTb.sv ====
// processor testbench: random programs, memory models and a store checker against the ISA model
`default_nettype none

module processorTb;

    localparam int clockPeriod  = 4;
    localparam int progWords    = 64;             // instruction memory depth
    localparam int bodyEnd      = 20;             // random code in words 1..bodyEnd
    localparam int numPrograms  = 8;
    localparam int watchdogTime = numPrograms * progWords * 40 * clockPeriod;

    `include "isaModel.svh"

    logic         Clock       = 1'b0;
    logic         reset       = 1'b1;
    logic         Enable      = 1'b1;
    logic         DataWaitreq = 1'b0;
    cpuIsa::wordT InstrIn;
    cpuIsa::wordT DataIn;
    cpuIsa::wordT InstrAddr;
    cpuIsa::wordT DataAddr;
    cpuIsa::wordT DataOut;
    logic         ReadData;
    logic         WriteData;
    cpuIsa::wordT instrMem [progWords];
    cpuIsa::wordT dataMem [256];
    cpuIsa::wordT image [256];                    // data memory at program start
    storeT        observed [$];                   // completed stores from the data port
    storeT        expected [$];                   // stores predicted by the model
    logic [31:0]  progRng  = 32'd50;
    logic [31:0]  noiseRng = 32'd50;
    logic         noisy    = 1'b0;                // random Enable and DataWaitreq
    int           matched  = 0;

    processor #(.resetPc(16'h0000)) processor_i (
        .Clock, .reset, .Enable, .InstrIn, .DataIn, .DataWaitreq,
        .InstrAddr, .DataAddr, .DataOut, .ReadData, .WriteData
    );

    assign InstrIn = instrMem[InstrAddr[5:0]];    // answers in the same cycle
    assign DataIn  = ReadData ? dataMem[DataAddr[7:0]] : '0;   // data only on a read strobe

    always #(clockPeriod / 2) Clock = ~Clock;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        return s ^ (s << 5);
    endfunction

    function automatic cpuIsa::wordT encode(input logic [2:0] op, input logic m,
                                            input logic [2:0] x, input logic [8:0] field);
        return {op, m, x, field};
    endfunction

    task automatic checkValue(input string name, input cpuIsa::wordT got,
                              input cpuIsa::wordT want);
        if (got !== want) begin
            $display("ERR %s: got %h, expected %h", name, got, want);
            $display("Test FAILED");
            $fatal(1);
        end
    endtask

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic makeProgram();
        logic [31:0] r;
        logic [8:0]  regField;
        logic [8:0]  opnd;
        int          i;
        int          off;
        for (int a = 0; a < 256; a++) begin
            progRng  = xorshift(progRng);
            image[a] = progRng[15:0] ^ 16'(a);
            if (a < progWords) begin
                instrMem[a] = encode(3'd7, 1'b0, 3'd0, 9'd0);   // nop filler
            end
        end
        instrMem[0] = encode(3'd1, 1'b0, 3'd0, 9'd39);          // forward to the detour at 40
        i = 1;
        while (i <= bodyEnd) begin
            progRng  = xorshift(progRng);
            r        = progRng;
            regField = {6'd0, r[10:8]};
            opnd     = r[4] ? r[20:12] : regField;
            case (r[2:0])
                3'd0: instrMem[i] = encode(3'd0, r[4], r[7:5], opnd);
                3'd1: instrMem[i] = encode(3'd1, 1'b1, r[7:5], r[20:12]);
                3'd2: instrMem[i] = encode(3'd2, r[4], r[7:5], opnd);
                3'd3: instrMem[i] = encode(r[21] ? 3'd3 : 3'd6, r[4], r[7:5], opnd);
                3'd4: instrMem[i] = encode(3'd4, 1'b0, r[7:5], regField);
                3'd5: instrMem[i] = encode(3'd5, 1'b0, r[7:5], regField);
                3'd6: begin
                    off = (i + int'(r[22:21]) % 3 > bodyEnd) ? 0 : int'(r[22:21]) % 3;
                    instrMem[i] = encode(3'd1, 1'b0, 3'd0, 9'(off));   // skip ahead
                end
                default: begin                    // store, then load back and use
                    instrMem[i] = encode(3'd5, 1'b0, r[7:5], regField);
                    if (i + 2 <= bodyEnd) begin
                        instrMem[i + 1] = encode(3'd4, 1'b0, r[23:21], regField);
                        instrMem[i + 2] = encode(3'd2, 1'b1, r[23:21], r[20:12]);
                        i += 2;
                    end
                end
            endcase
            i++;
        end
        instrMem[21] = encode(3'd5, 1'b0, 3'd7, 9'd7);           // r7 to its own address
        for (int k = 0; k < 7; k++) begin
            instrMem[22 + 2 * k] = encode(3'd0, 1'b1, 3'd7, 9'(240 + k));
            instrMem[23 + 2 * k] = encode(3'd5, 1'b0, 3'(k), 9'd7);
        end
        instrMem[36] = encode(3'd1, 1'b0, 3'd0, 9'h1FF);         // branch to itself
        for (int a = 40; a < 44; a++) begin
            progRng     = xorshift(progRng);
            instrMem[a] = encode(progRng[0] ? 3'd2 : 3'd3, 1'b1, progRng[7:5], progRng[20:12]);
        end
        instrMem[44] = encode(3'd1, 1'b0, 3'd0, 9'h1D4);         // back to word 1
        instrMem[45] = encode(3'd5, 1'b0, 3'd0, 9'd0);           // flushed slots, never stored
        instrMem[46] = encode(3'd5, 1'b0, 3'd1, 9'd1);
    endtask

    always @(posedge Clock) begin
        #1;
        noiseRng    = xorshift(noiseRng);
        Enable      = !noisy || noiseRng[2:0] != 3'd0;
        DataWaitreq = noisy && noiseRng[5:4] == 2'd0;
    end

    // data memory and store capture
    always @(posedge Clock) begin
        if (reset) begin
            dataMem = image;
        end else begin
            if (!Enable) begin
                checkValue("ReadData", 16'(ReadData), '0);
                checkValue("WriteData", 16'(WriteData), '0);
            end
            if (ReadData && WriteData) begin
                abortRun("ReadData and WriteData were high in the same cycle");
            end
            if (Enable && WriteData && !DataWaitreq) begin
                observed.push_back('{addr: DataAddr, data: DataOut});
                dataMem[DataAddr[7:0]] = DataOut;
            end
        end
    end

    always @(negedge Clock) begin
        storeT seen;
        storeT want;
        while (observed.size() > 0) begin
            seen = observed.pop_front();
            if (expected.size() == 0) begin
                abortRun($sformatf("extra store of %h to address %h", seen.data, seen.addr));
            end else begin
                want = expected.pop_front();
                checkValue("DataAddr", seen.addr, want.addr);
                checkValue("DataOut", seen.data, want.data);
                matched++;
            end
        end
    end

    initial begin
        int target;
        int cycles;
        for (int p = 0; p < numPrograms; p++) begin
            @(posedge Clock);
            noisy = 1'b0;                         // quiet while in reset
            #1;
            reset = 1'b1;
            makeProgram();
            runModel(instrMem, image, expected);
            target = matched + expected.size();
            repeat (16) @(posedge Clock);
            checkValue("InstrAddr", InstrAddr, '0);
            checkValue("ReadData", 16'(ReadData), '0);
            checkValue("WriteData", 16'(WriteData), '0);
            noisy  = (p != 0);                    // first program runs undisturbed
            #1;
            reset  = 1'b0;
            cycles = 0;
            while (matched < target && cycles < progWords * 30) begin
                @(posedge Clock);
                cycles++;
            end
            if (matched < target) begin
                abortRun($sformatf("program %0d stopped with %0d stores missing", p,
                                   target - matched));
            end
            repeat (20) @(posedge Clock);         // room for a stray store to show up
        end
        $display("Test OK");
        $finish;
    end

    initial begin
        #(watchdogTime);
        $display("watchdog timeout, the run did not finish in %0d time units", watchdogTime);
        $display("Test FAILED");
        $fatal(1);
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+tests
source/cpuIsa.sv
source/pipeLatch.sv
source/fetchStage.sv
source/registerFile.sv
source/decodeStage.sv
source/executeStage.sv
source/memoryStage.sv
source/processor.sv
tests/processorTb.sv

// ==== Makefile ====
TOP = processorTb

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing -j 0 --top-module $(TOP) -Mdir obj_dir -f files.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir
